/* ex_macros.svh */
// Widths are fixed by the 32-bit instruction set and are not meant to be overridden
// Shift amounts are sized from EX_DATA_W where they are used
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// --------------------
// Datapath widths
// --------------------
`define EX_DATA_W   32  // Operands, PC, immediate
`define EX_PROD_W   64  // Full multiplier product

// --------------------
// Field widths
// --------------------
`define EX_RADDR_W  5   // Register file address
`define EX_FUNC_W   6   // Func field of the instruction
`define EX_MEMFN_W  3   // Memory access function

`define EX_PC_STEP  4   // Bytes per instruction

`endif

/* exPkg.sv */
// Types shared by the execute stage; ALU and branch codes overlap on Func
// The op bits from decode decide which table a Func value belongs to
`default_nettype none
`include "ex_macros.svh"

package exPkg;

    // --------------------
    // ALU function codes
    // --------------------
    typedef enum logic [`EX_FUNC_W-1:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_MULT  = 6'h18,  // Handled by the multiplier
        FN_MULTU = 6'h19,  // Handled by the multiplier
        FN_ADD   = 6'h20,
        FN_ADDU  = 6'h21,
        FN_SUB   = 6'h22,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2A
    } aluFuncE;

    // --------------------
    // Branch function codes
    // --------------------
    typedef enum logic [`EX_FUNC_W-1:0] {
        BR_J    = 6'h02,
        BR_JAL  = 6'h03,
        BR_BEQ  = 6'h04,
        BR_BNE  = 6'h05,
        BR_BLEZ = 6'h06,
        BR_BGTZ = 6'h07,
        BR_JR   = 6'h08
    } braFuncE;

    // Which unit drives Out and the flags
    typedef enum logic [1:0] {
        SEL_ALU = 2'b00,
        SEL_BRA = 2'b01,
        SEL_MUL = 2'b10
    } outSelE;

endpackage

`default_nettype wire

/* exCtrlIf.sv */
// Control to datapath bundle; all signals are combinational levels
// No handshake, values are valid in every cycle
`timescale 1ns/10ps
`default_nettype none

interface exCtrlIf
    import exPkg::*;
();

    logic   aluEn;      // ALU produces a result
    logic   braEn;      // Branch unit may redirect the PC
    logic   mulSigned;  // MULT rather than MULTU
    outSelE outSel;     // Result and flag source

    modport ctrl (
        output aluEn, braEn, mulSigned, outSel
    );

    modport dp (
        input aluEn, braEn, mulSigned, outSel
    );

endinterface

`default_nettype wire

/* exAlu.sv */
// Combinational 32-bit ALU; MULT/MULTU codes give a zero result here
// All outputs, flags included, are zero while the ALU is disabled
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module exAlu
    import exPkg::*;
(
    input  logic [`EX_DATA_W-1:0]         A,
    input  logic [`EX_DATA_W-1:0]         B,
    input  logic [$clog2(`EX_DATA_W)-1:0] Shamt,
    input  aluFuncE                       Func,
    exCtrlIf.dp                           ctrl,
    output logic [`EX_DATA_W-1:0]         Out,
    output logic                          C,
    output logic                          Z,
    output logic                          O,
    output logic                          N
);

    logic [`EX_DATA_W:0]   sum;    // Extra bit holds the carry
    logic [`EX_DATA_W:0]   diff;   // Extra bit is set when no borrow
    logic [`EX_DATA_W-1:0] res;
    logic                  carry;
    logic                  ovf;

    assign sum  = {1'b0, A} + {1'b0, B};
    assign diff = {1'b0, A} + {1'b0, ~B} + 1'b1;

    always_comb begin
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (Func)
            FN_SLL:  res = B << Shamt;
            FN_SRL:  res = B >> Shamt;
            FN_SRA:  res = $signed(B) >>> Shamt;
            FN_ADD: begin
                res   = sum[`EX_DATA_W-1:0];
                carry = sum[`EX_DATA_W];
                ovf   = (A[`EX_DATA_W-1] == B[`EX_DATA_W-1]) &&
                        (res[`EX_DATA_W-1] != A[`EX_DATA_W-1]);  // Same signs in, other sign out
            end
            FN_ADDU: begin
                res   = sum[`EX_DATA_W-1:0];
                carry = sum[`EX_DATA_W];
            end
            FN_SUB: begin
                res   = diff[`EX_DATA_W-1:0];
                carry = diff[`EX_DATA_W];
                ovf   = (A[`EX_DATA_W-1] != B[`EX_DATA_W-1]) &&
                        (res[`EX_DATA_W-1] != A[`EX_DATA_W-1]);
            end
            FN_SUBU: begin
                res   = diff[`EX_DATA_W-1:0];
                carry = diff[`EX_DATA_W];
            end
            FN_AND:  res = A & B;
            FN_OR:   res = A | B;
            FN_XOR:  res = A ^ B;
            FN_NOR:  res = ~(A | B);
            FN_SLT:  res = {{(`EX_DATA_W-1){1'b0}}, $signed(A) < $signed(B)};  // Signed compare
            default: res = '0;
        endcase
    end

    assign Out = ctrl.aluEn ? res : '0;
    assign C   = ctrl.aluEn & carry;
    assign Z   = ctrl.aluEn & (res == '0);
    assign O   = ctrl.aluEn & ovf;
    assign N   = ctrl.aluEn & res[`EX_DATA_W-1];

endmodule

`default_nettype wire

/* exBranch.sv */
// Taken branch target is PCin+4 plus Address shifted left by two
// J and JAL jump to Address, JR jumps to A; PCout is PCin+4 otherwise
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module exBranch
    import exPkg::*;
(
    input  logic                  Enable,
    input  logic [`EX_DATA_W-1:0] PCin,
    input  logic [`EX_DATA_W-1:0] A,
    input  logic [`EX_DATA_W-1:0] B,
    input  logic [`EX_DATA_W-1:0] Address,  // Branch offset or jump target
    input  braFuncE               Func,
    output logic [`EX_DATA_W-1:0] PCout,
    output logic [`EX_DATA_W-1:0] Ret,      // Return address for JAL
    output logic                  Taken
);

    logic                  cond;
    logic [`EX_DATA_W-1:0] target;

    assign Ret = PCin + `EX_DATA_W'(`EX_PC_STEP);

    always_comb begin
        cond   = 1'b0;
        target = Ret + {Address[`EX_DATA_W-3:0], 2'b00};  // Word offset
        case (Func)
            BR_BEQ:  cond = (A == B);
            BR_BNE:  cond = (A != B);
            BR_BLEZ: cond = A[`EX_DATA_W-1] | (A == '0);
            BR_BGTZ: cond = ~A[`EX_DATA_W-1] & (A != '0);
            BR_J, BR_JAL: begin
                cond   = 1'b1;
                target = Address;
            end
            BR_JR: begin
                cond   = 1'b1;
                target = A;  // Register indirect
            end
            default: cond = 1'b0;
        endcase
    end

    assign Taken = Enable & cond;
    assign PCout = Taken ? target : Ret;

endmodule

`default_nettype wire

/* exMult.sv */
// Single-cycle 32x32 multiply giving the full 64-bit product
// C and O are always zero; Z and N follow the product
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module exMult
    import exPkg::*;
(
    input  logic [`EX_DATA_W-1:0] A,
    input  logic [`EX_DATA_W-1:0] B,
    exCtrlIf.dp                   ctrl,
    output logic [`EX_PROD_W-1:0] Out,
    output logic                  C,
    output logic                  Z,
    output logic                  O,
    output logic                  N
);

    logic                  extA;  // Sign fill for A
    logic                  extB;  // Sign fill for B
    logic [`EX_PROD_W-1:0] prod;

    // One multiplier for both forms: extend by sign or by zero, keep low 64 bits
    assign extA = ctrl.mulSigned & A[`EX_DATA_W-1];
    assign extB = ctrl.mulSigned & B[`EX_DATA_W-1];
    assign prod = {{`EX_DATA_W{extA}}, A} * {{`EX_DATA_W{extB}}, B};

    assign Out = prod;
    assign C   = 1'b0;
    assign O   = 1'b0;
    assign Z   = (prod == '0);
    assign N   = prod[`EX_PROD_W-1];

endmodule

`default_nettype wire

/* exControl.sv */
// MULOp has priority over Jump/Branch, which have priority over ALUOp
// With no op bit set the ALU stays disabled and the stage outputs zero
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module exControl
    import exPkg::*;
(
    input  logic                 ALUOp,
    input  logic                 MULOp,
    input  logic                 Jump,
    input  logic                 Branch,
    input  logic                 RegWriteIn,
    input  logic                 braTaken,    // From the branch unit
    input  logic [`EX_FUNC_W-1:0] Func,
    exCtrlIf.ctrl                ctrl,
    output logic                 ACCEn,
    output logic                 RegWriteOut,
    output logic                 BranchTaken
);

    logic braPath;  // Branch unit owns the result

    assign braPath = (Jump | Branch) & ~MULOp;

    // --------------------
    // Unit enables and select
    // --------------------
    always_comb begin
        ctrl.aluEn  = 1'b0;
        ctrl.braEn  = 1'b0;
        ctrl.outSel = SEL_ALU;
        if (MULOp) begin
            ctrl.outSel = SEL_MUL;
        end else if (Jump | Branch) begin
            ctrl.braEn  = 1'b1;
            ctrl.outSel = SEL_BRA;
        end else if (ALUOp) begin
            ctrl.aluEn  = 1'b1;
        end
    end

    assign ctrl.mulSigned = (Func == FN_MULT);

    // --------------------
    // Write enables
    // --------------------
    assign ACCEn       = MULOp;               // Product goes to HI/LO
    assign BranchTaken = braPath & braTaken;

    // No register write for a multiply or a branch that falls through
    assign RegWriteOut = RegWriteIn & ~MULOp & ~(braPath & ~braTaken);

endmodule

`default_nettype wire

/* exStage1.sv */
// Purely combinational execute datapath; registering is done by the caller
// The multiplier shares operand B with the ALU, so ALUSrc applies to both
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module exStage1
    import exPkg::*;
(
    input  logic                          ALUOp,
    input  logic                          MULOp,
    input  logic                          Jump,
    input  logic                          Branch,
    input  logic                          RegWriteIn,
    input  logic                          MemReadIn,
    input  logic                          MemtoRegIn,
    input  logic                          MemWriteIn,
    input  logic                          ALUSrc,      // Immediate as ALU operand B
    input  logic                          BRASrc,      // Immediate as branch address
    input  logic [`EX_DATA_W-1:0]         A,
    input  logic [`EX_DATA_W-1:0]         B,
    input  logic [`EX_DATA_W-1:0]         Immediate,
    input  logic [`EX_DATA_W-1:0]         PCin,
    input  logic [$clog2(`EX_DATA_W)-1:0] Shamt,
    input  logic [`EX_RADDR_W-1:0]        RAddrIn,
    input  logic [`EX_FUNC_W-1:0]         Func,
    input  logic [`EX_MEMFN_W-1:0]        MemfuncIn,
    output logic [`EX_PROD_W-1:0]         Out,
    output logic [`EX_RADDR_W-1:0]        RAddrOut,
    output logic [`EX_MEMFN_W-1:0]        MemfuncOut,
    output logic [`EX_DATA_W-1:0]         RtDataOut,
    output logic [`EX_DATA_W-1:0]         PCout,
    output logic                          C,
    output logic                          Z,
    output logic                          O,
    output logic                          N,
    output logic                          RegWriteOut,
    output logic                          MemReadOut,
    output logic                          MemtoRegOut,
    output logic                          MemWriteOut,
    output logic                          BranchTaken,
    output logic                          ACCEn
);

    logic [`EX_DATA_W-1:0] opB;      // ALU and multiplier operand B
    logic [`EX_DATA_W-1:0] braBase;  // Offset or target for the branch unit
    logic [`EX_DATA_W-1:0] aluOut;
    logic [`EX_DATA_W-1:0] braRet;
    logic [`EX_PROD_W-1:0] mulOut;
    logic                  aluC, aluZ, aluO, aluN;
    logic                  mulC, mulZ, mulO, mulN;
    logic                  braTaken;

    exCtrlIf ctrlBus ();

    assign opB     = ALUSrc ? Immediate : B;
    assign braBase = BRASrc ? Immediate : A;

    // --------------------
    // Units
    // --------------------
    exControl uControl (
        .ALUOp(ALUOp), .MULOp(MULOp), .Jump(Jump), .Branch(Branch),
        .RegWriteIn(RegWriteIn), .braTaken(braTaken), .Func(Func), .ctrl(ctrlBus),
        .ACCEn(ACCEn), .RegWriteOut(RegWriteOut), .BranchTaken(BranchTaken)
    );

    exAlu uAlu (
        .A(A), .B(opB), .Shamt(Shamt), .Func(aluFuncE'(Func)), .ctrl(ctrlBus),
        .Out(aluOut), .C(aluC), .Z(aluZ), .O(aluO), .N(aluN)
    );

    exBranch uBranch (
        .Enable(ctrlBus.braEn), .PCin(PCin), .A(A), .B(B), .Address(braBase),
        .Func(braFuncE'(Func)), .PCout(PCout), .Ret(braRet), .Taken(braTaken)
    );

    exMult uMult (
        .A(A), .B(opB), .ctrl(ctrlBus),
        .Out(mulOut), .C(mulC), .Z(mulZ), .O(mulO), .N(mulN)
    );

    // --------------------
    // Result and flag select
    // --------------------
    always_comb begin
        case (ctrlBus.outSel)
            SEL_ALU: begin
                Out          = {{(`EX_PROD_W-`EX_DATA_W){1'b0}}, aluOut};
                {C, Z, O, N} = {aluC, aluZ, aluO, aluN};
            end
            SEL_BRA: begin
                Out          = {{(`EX_PROD_W-`EX_DATA_W){1'b0}}, braRet};  // Link value
                {C, Z, O, N} = 4'b0000;
            end
            SEL_MUL: begin
                Out          = mulOut;
                {C, Z, O, N} = {mulC, mulZ, mulO, mulN};
            end
            default: begin
                Out          = '0;
                {C, Z, O, N} = 4'b0000;
            end
        endcase
    end

    assign RAddrOut    = RAddrIn;
    assign MemfuncOut  = MemfuncIn;
    assign RtDataOut   = B;           // Store data for the memory stage
    assign MemReadOut  = MemReadIn;
    assign MemtoRegOut = MemtoRegIn;
    assign MemWriteOut = MemWriteIn;

endmodule

`default_nettype wire

/* exStageTop.sv */
// Execute stage with the EX/MEM register; every output lags its inputs by one cycle
// No stall or flush input, a new operation is accepted on every Clock edge
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module exStageTop (
    input  logic                          Clock,
    input  logic                          rst,
    input  logic                          ALUOp,
    input  logic                          MULOp,
    input  logic                          Jump,
    input  logic                          Branch,
    input  logic                          RegWriteIn,
    input  logic                          MemReadIn,
    input  logic                          MemtoRegIn,
    input  logic                          MemWriteIn,
    input  logic                          ALUSrc,
    input  logic                          BRASrc,
    input  logic [`EX_DATA_W-1:0]         A,
    input  logic [`EX_DATA_W-1:0]         B,
    input  logic [`EX_DATA_W-1:0]         Immediate,
    input  logic [`EX_DATA_W-1:0]         PCin,
    input  logic [$clog2(`EX_DATA_W)-1:0] Shamt,
    input  logic [`EX_RADDR_W-1:0]        RAddrIn,
    input  logic [`EX_FUNC_W-1:0]         Func,
    input  logic [`EX_MEMFN_W-1:0]        MemfuncIn,
    output logic [`EX_PROD_W-1:0]         Out,
    output logic [`EX_RADDR_W-1:0]        RAddrOut,
    output logic [`EX_MEMFN_W-1:0]        MemfuncOut,
    output logic [`EX_DATA_W-1:0]         RtDataOut,
    output logic [`EX_DATA_W-1:0]         PCout,
    output logic                          C,
    output logic                          Z,
    output logic                          O,
    output logic                          N,
    output logic                          RegWriteOut,
    output logic                          MemReadOut,
    output logic                          MemtoRegOut,
    output logic                          MemWriteOut,
    output logic                          BranchTaken,
    output logic                          ACCEn
);

    logic [`EX_PROD_W-1:0]  outNxt;
    logic [`EX_RADDR_W-1:0] rAddrNxt;
    logic [`EX_MEMFN_W-1:0] memfuncNxt;
    logic [`EX_DATA_W-1:0]  rtDataNxt;
    logic [`EX_DATA_W-1:0]  pcNxt;
    logic [3:0]             flagsNxt;  // C, Z, O, N
    logic [5:0]             ctlNxt;    // Write enables and branch outcome

    exStage1 uStage (
        .ALUOp(ALUOp), .MULOp(MULOp), .Jump(Jump), .Branch(Branch),
        .RegWriteIn(RegWriteIn), .MemReadIn(MemReadIn), .MemtoRegIn(MemtoRegIn),
        .MemWriteIn(MemWriteIn), .ALUSrc(ALUSrc), .BRASrc(BRASrc),
        .A(A), .B(B), .Immediate(Immediate), .PCin(PCin), .Shamt(Shamt),
        .RAddrIn(RAddrIn), .Func(Func), .MemfuncIn(MemfuncIn),
        .Out(outNxt), .RAddrOut(rAddrNxt), .MemfuncOut(memfuncNxt),
        .RtDataOut(rtDataNxt), .PCout(pcNxt),
        .C(flagsNxt[3]), .Z(flagsNxt[2]), .O(flagsNxt[1]), .N(flagsNxt[0]),
        .RegWriteOut(ctlNxt[5]), .MemReadOut(ctlNxt[4]), .MemtoRegOut(ctlNxt[3]),
        .MemWriteOut(ctlNxt[2]), .BranchTaken(ctlNxt[1]), .ACCEn(ctlNxt[0])
    );

    // --------------------
    // EX/MEM register
    // --------------------
    always_ff @(posedge Clock) begin
        if (rst) begin
            Out          <= '0;
            RAddrOut     <= '0;
            MemfuncOut   <= '0;
            RtDataOut    <= '0;
            PCout        <= '0;
            {C, Z, O, N} <= 4'b0000;
            {RegWriteOut, MemReadOut, MemtoRegOut, MemWriteOut, BranchTaken, ACCEn} <= '0;
        end else begin
            Out          <= outNxt;
            RAddrOut     <= rAddrNxt;
            MemfuncOut   <= memfuncNxt;
            RtDataOut    <= rtDataNxt;
            PCout        <= pcNxt;
            {C, Z, O, N} <= flagsNxt;
            {RegWriteOut, MemReadOut, MemtoRegOut, MemWriteOut, BranchTaken, ACCEn} <=
                ctlNxt;
        end
    end

endmodule

`default_nettype wire

/* exStage_assert.sv */
// Concurrent checks on the registered stage outputs, bound into exStageTop
// Flags are sampled one cycle after the inputs that produced them
`timescale 1ns/10ps
`default_nettype none

module exStageAssert (
    input wire logic Clock,
    input wire logic rst,
    input wire logic Jump,
    input wire logic Branch,
    input wire logic MULOp,
    input wire logic ACCEn,
    input wire logic RegWriteOut,
    input wire logic BranchTaken,
    input wire logic MemReadOut,
    input wire logic MemtoRegOut,
    input wire logic MemWriteOut,
    input wire logic C,
    input wire logic Z,
    input wire logic O,
    input wire logic N
);

    // Multiply result goes to HI/LO only
    accNoWrite: assert property (@(posedge Clock) disable iff (rst)
        ACCEn |-> !RegWriteOut)
        else $error("ACCEn with RegWriteOut high");

    // Branch path never raises a flag
    braNoFlags: assert property (@(posedge Clock) disable iff (rst)
        ($past((Jump | Branch) & ~MULOp) && !BranchTaken) |-> !(C | Z | O | N))
        else $error("Flags set on an untaken branch result");

    // Control outputs cleared by reset
    rstClears: assert property (@(posedge Clock)
        rst |=> !(RegWriteOut | MemReadOut | MemtoRegOut | MemWriteOut | BranchTaken | ACCEn))
        else $error("Control outputs not cleared after reset");

endmodule

bind exStageTop exStageAssert uAssert (.*);

`default_nettype wire

/* tbExStage.sv */
// Table-driven and random test of exStageTop; checks every output one cycle after its inputs
// Expected values for random operations come from a behavioral model in this file
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module tbExStage
    import exPkg::*;
();

    typedef struct packed {
        logic [3:0]  ops;     // ALUOp, MULOp, Jump, Branch
        logic [2:0]  ctl;     // RegWriteIn, ALUSrc, BRASrc
        logic [5:0]  func;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [63:0] eOut;
        logic [3:0]  eFlg;    // C, Z, O, N
        logic [31:0] ePc;
        logic [2:0]  eCtl;    // BranchTaken, RegWriteOut, ACCEn
    } vecT;

    localparam logic [31:0] PC0 = 32'h0000_0100;
    localparam logic [31:0] PC4 = 32'h0000_0104;
    localparam int NTBL = 24;
    localparam int NRND = 200;

    logic Clock, rst, ALUOp, MULOp, Jump, Branch, RegWriteIn, MemReadIn, MemtoRegIn;
    logic MemWriteIn, ALUSrc, BRASrc;
    logic [31:0] A, B, Immediate, PCin, RtDataOut, PCout;
    logic [4:0]  Shamt, RAddrIn, RAddrOut;
    logic [5:0]  Func;
    logic [2:0]  MemfuncIn, MemfuncOut;
    logic [63:0] Out;
    logic C, Z, O, N, RegWriteOut, MemReadOut, MemtoRegOut, MemWriteOut, BranchTaken, ACCEn;

    vecT         tbl [0:NTBL-1];
    vecT         prev;
    logic [4:0]  pRAddr;
    logic [2:0]  pMemfn, pMemBits;
    logic [31:0] pRt;
    integer      seed = 32'h187b_e301;
    int          errors = 0;
    int          checks = 0;

    exStageTop DUT (.*);

    always #10 Clock = ~Clock;

    // --------------------
    // Behavioral model
    // --------------------
    function automatic vecT model(vecT v);
        logic [31:0] opB, base, pc4, res;
        logic [32:0] s33;
        logic [63:0] p;
        longint      sa, sb, sl;
        logic        c, o, tk;
        sa = $signed(v.a);
        opB = v.ctl[1] ? v.imm : v.b;
        sb = $signed(opB);
        base = v.ctl[0] ? v.imm : v.a;
        pc4 = v.pc + 32'd4;
        v.eOut = '0;
        v.eFlg = 4'b0000;
        v.ePc = pc4;
        v.eCtl = {1'b0, v.ctl[2], 1'b0};
        if (v.ops[2]) begin
            if (v.func == FN_MULT) p = sa * sb;
            else p = {32'b0, v.a} * {32'b0, opB};
            v.eOut = p;
            v.eFlg = {1'b0, p == 64'b0, 1'b0, p[63]};
            v.eCtl = 3'b001;
        end else if (v.ops[1] | v.ops[0]) begin
            tk = 1'b0;
            v.ePc = pc4 + {base[29:0], 2'b00};
            case (v.func)
                BR_BEQ:  tk = (v.a == v.b);
                BR_BNE:  tk = (v.a != v.b);
                BR_BLEZ: tk = (sa <= 0);
                BR_BGTZ: tk = (sa > 0);
                BR_J, BR_JAL: begin
                    tk = 1'b1;
                    v.ePc = base;
                end
                BR_JR: begin
                    tk = 1'b1;
                    v.ePc = v.a;
                end
                default: tk = 1'b0;
            endcase
            if (!tk) v.ePc = pc4;
            v.eOut = {32'b0, pc4};
            v.eCtl = {tk, v.ctl[2] & tk, 1'b0};
        end else if (v.ops[3]) begin
            c = 1'b0;
            o = 1'b0;
            res = '0;
            case (v.func)
                FN_ADD, FN_ADDU: begin
                    s33 = {1'b0, v.a} + {1'b0, opB};
                    res = s33[31:0];
                    c = s33[32];
                    sl = sa + sb;
                    o = (v.func == FN_ADD) && (sl > 64'sd2147483647 || sl < -64'sd2147483648);
                end
                FN_SUB, FN_SUBU: begin
                    res = v.a - opB;
                    c = (v.a >= opB);  // No borrow
                    sl = sa - sb;
                    o = (v.func == FN_SUB) && (sl > 64'sd2147483647 || sl < -64'sd2147483648);
                end
                FN_AND: res = v.a & opB;
                FN_OR:  res = v.a | opB;
                FN_XOR: res = v.a ^ opB;
                FN_NOR: res = ~(v.a | opB);
                FN_SLL: res = opB << v.shamt;
                FN_SRL: res = opB >> v.shamt;
                FN_SRA: res = 32'($signed(opB) >>> v.shamt);
                FN_SLT: res = {31'b0, sa < sb};
                default: res = '0;
            endcase
            v.eOut = {32'b0, res};
            v.eFlg = {c, res == 32'b0, o, res[31]};
        end
        return v;
    endfunction

    task automatic reportErr(input string name, input logic [63:0] got, input logic [63:0] exp);
        errors++;
        $display("[ERROR] %s: got %h expected %h", name, got, exp);
    endtask

    // Compare registered outputs against the operation driven one edge earlier
    task automatic checkOut(input vecT e);
        checks++;
        if (Out !== e.eOut) reportErr("Out", Out, e.eOut);
        if ({C, Z, O, N} !== e.eFlg) reportErr("CZON", 64'({C, Z, O, N}), 64'(e.eFlg));
        if (PCout !== e.ePc) reportErr("PCout", 64'(PCout), 64'(e.ePc));
        if (BranchTaken !== e.eCtl[2]) reportErr("BranchTaken", 64'(BranchTaken), 64'(e.eCtl[2]));
        if (RegWriteOut !== e.eCtl[1]) reportErr("RegWriteOut", 64'(RegWriteOut), 64'(e.eCtl[1]));
        if (ACCEn !== e.eCtl[0]) reportErr("ACCEn", 64'(ACCEn), 64'(e.eCtl[0]));
        if (RAddrOut !== pRAddr) reportErr("RAddrOut", 64'(RAddrOut), 64'(pRAddr));
        if (MemfuncOut !== pMemfn) reportErr("MemfuncOut", 64'(MemfuncOut), 64'(pMemfn));
        if (RtDataOut !== pRt) reportErr("RtDataOut", 64'(RtDataOut), 64'(pRt));
        if ({MemReadOut, MemtoRegOut, MemWriteOut} !== pMemBits)
            reportErr("MemBits", 64'({MemReadOut, MemtoRegOut, MemWriteOut}), 64'(pMemBits));
    endtask

    task automatic driveVec(input vecT v);
        {ALUOp, MULOp, Jump, Branch} = v.ops;
        {RegWriteIn, ALUSrc, BRASrc} = v.ctl;
        Func = v.func;
        Shamt = v.shamt;
        A = v.a;
        B = v.b;
        Immediate = v.imm;
        PCin = v.pc;
        RAddrIn = 5'($random(seed));
        MemfuncIn = 3'($random(seed));
        {MemReadIn, MemtoRegIn, MemWriteIn} = 3'($random(seed));
        pRAddr = RAddrIn;
        pMemfn = MemfuncIn;
        pRt = v.b;
        pMemBits = {MemReadIn, MemtoRegIn, MemWriteIn};
    endtask

    // One operation per cycle, each checked at the following edge
    task automatic stepVec(input vecT v, input bit havePrev);
        @(posedge Clock);
        #2;
        if (havePrev) checkOut(prev);
        driveVec(v);
        prev = v;
    endtask

    function automatic vecT randVec();
        vecT v;
        aluFuncE aluCodes [11] = '{FN_SLL, FN_SRL, FN_SRA, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                                   FN_AND, FN_OR, FN_XOR, FN_NOR};
        braFuncE braCodes [7] = '{BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ, BR_J, BR_JAL, BR_JR};
        int k;
        v = '0;
        v.ctl = 3'($random(seed));
        v.shamt = 5'($random(seed));
        v.a = $random(seed);
        v.b = ($random(seed) & 1) ? v.a : $random(seed);  // Equal operands now and then
        v.imm = $random(seed);
        v.pc = {$random(seed)} & 32'hFFFF_FFFC;
        k = {$random(seed)} % 4;
        case (k)
            0: begin
                v.ops = 4'b0100;
                v.func = ($random(seed) & 1) ? FN_MULT : FN_MULTU;
            end
            1: begin
                v.func = braCodes[{$random(seed)} % 7];
                v.ops = (v.func inside {BR_J, BR_JAL, BR_JR}) ? 4'b0010 : 4'b0001;
            end
            2: begin
                v.ops = 4'b1000;
                v.func = FN_SLT;
            end
            default: begin
                v.ops = 4'b1000;
                v.func = aluCodes[{$random(seed)} % 11];
            end
        endcase
        return model(v);
    endfunction

    initial begin
        #(20 * (NTBL + NRND + 100));
        $display("Timeout: the test did not complete in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int guard;
        Clock = 0;
        rst = 1;
        tbl[0]  = '{4'b1000, 3'b100, FN_ADD, 5'd0, 32'h7FFFFFFF, 32'h1, 32'h0, PC0,
                    64'h8000_0000, 4'b0011, PC4, 3'b010};
        tbl[1]  = '{4'b1000, 3'b100, FN_ADD, 5'd0, 32'hFFFFFFFF, 32'h1, 32'h0, PC0,
                    64'h0, 4'b1100, PC4, 3'b010};
        tbl[2]  = '{4'b1000, 3'b100, FN_SUB, 5'd0, 32'h0, 32'h1, 32'h0, PC0,
                    64'hFFFF_FFFF, 4'b0001, PC4, 3'b010};
        tbl[3]  = '{4'b1000, 3'b100, FN_SUB, 5'd0, 32'h5, 32'h5, 32'h0, PC0,
                    64'h0, 4'b1100, PC4, 3'b010};
        tbl[4]  = '{4'b1000, 3'b100, FN_SUB, 5'd0, 32'h80000000, 32'h1, 32'h0, PC0,
                    64'h7FFF_FFFF, 4'b1010, PC4, 3'b010};
        tbl[5]  = '{4'b1000, 3'b100, FN_AND, 5'd0, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h0, PC0,
                    64'h00F0_00F0, 4'b0000, PC4, 3'b010};
        tbl[6]  = '{4'b1000, 3'b100, FN_OR, 5'd0, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h0, PC0,
                    64'hFFF0_FFF0, 4'b0001, PC4, 3'b010};
        tbl[7]  = '{4'b1000, 3'b100, FN_XOR, 5'd0, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h0, PC0,
                    64'hFF00_FF00, 4'b0001, PC4, 3'b010};
        tbl[8]  = '{4'b1000, 3'b100, FN_NOR, 5'd0, 32'h0, 32'h0, 32'h0, PC0,
                    64'hFFFF_FFFF, 4'b0001, PC4, 3'b010};
        tbl[9]  = '{4'b1000, 3'b100, FN_SLL, 5'd31, 32'h0, 32'h1, 32'h0, PC0,
                    64'h8000_0000, 4'b0001, PC4, 3'b010};
        tbl[10] = '{4'b1000, 3'b100, FN_SRA, 5'd4, 32'h0, 32'h80000000, 32'h0, PC0,
                    64'hF800_0000, 4'b0001, PC4, 3'b010};
        tbl[11] = '{4'b1000, 3'b100, FN_SRL, 5'd4, 32'h0, 32'h80000000, 32'h0, PC0,
                    64'h0800_0000, 4'b0000, PC4, 3'b010};
        tbl[12] = '{4'b1000, 3'b100, FN_SLT, 5'd0, 32'hFFFFFFFF, 32'h1, 32'h0, PC0,
                    64'h1, 4'b0000, PC4, 3'b010};
        tbl[13] = '{4'b1000, 3'b110, FN_ADDU, 5'd0, 32'h10, 32'hDEAD, 32'h20, PC0,
                    64'h30, 4'b0000, PC4, 3'b010};
        tbl[14] = '{4'b0100, 3'b100, FN_MULT, 5'd0, 32'hFFFFFFFE, 32'h3, 32'h0, PC0,
                    64'hFFFF_FFFF_FFFF_FFFA, 4'b0001, PC4, 3'b001};
        tbl[15] = '{4'b0100, 3'b100, FN_MULTU, 5'd0, 32'hFFFFFFFE, 32'h3, 32'h0, PC0,
                    64'h0000_0002_FFFF_FFFA, 4'b0000, PC4, 3'b001};
        tbl[16] = '{4'b0100, 3'b100, FN_MULT, 5'd0, 32'h0, 32'h5, 32'h0, PC0,
                    64'h0, 4'b0100, PC4, 3'b001};
        tbl[17] = '{4'b0001, 3'b101, BR_BEQ, 5'd0, 32'h7, 32'h7, 32'h10, PC0,
                    64'h104, 4'b0000, 32'h144, 3'b110};
        tbl[18] = '{4'b0001, 3'b101, BR_BNE, 5'd0, 32'h7, 32'h7, 32'h10, PC0,
                    64'h104, 4'b0000, PC4, 3'b000};
        tbl[19] = '{4'b0001, 3'b101, BR_BNE, 5'd0, 32'h7, 32'h8, 32'hFFFFFFFF, PC0,
                    64'h104, 4'b0000, 32'h100, 3'b110};
        tbl[20] = '{4'b0010, 3'b101, BR_JAL, 5'd0, 32'h0, 32'h0, 32'h0040_0000, PC0,
                    64'h104, 4'b0000, 32'h0040_0000, 3'b110};
        tbl[21] = '{4'b0010, 3'b000, BR_JR, 5'd0, 32'h1230, 32'h0, 32'h0, PC0,
                    64'h104, 4'b0000, 32'h1230, 3'b100};
        tbl[22] = '{4'b0001, 3'b001, BR_BLEZ, 5'd0, 32'h0, 32'h9, 32'h4, PC0,
                    64'h104, 4'b0000, 32'h114, 3'b100};
        tbl[23] = '{4'b0000, 3'b100, FN_ADD, 5'd0, 32'h5, 32'h6, 32'h0, PC0,
                    64'h0, 4'b0000, PC4, 3'b010};

        // JAL with every memory bit set while rst is high
        driveVec(tbl[20]);
        {MemReadIn, MemtoRegIn, MemWriteIn} = 3'b111;

        repeat (5) @(posedge Clock);
        #2;
        rst = 0;
        guard = 0;
        while ((Out !== '0 || RegWriteOut !== 1'b0) && guard < 10) begin
            @(posedge Clock);
            guard++;
        end
        if (guard == 10) begin
            errors++;
            $display("Outputs did not clear after reset");
        end
        checks++;
        if ({RegWriteOut, MemReadOut, MemWriteOut, MemtoRegOut, BranchTaken, ACCEn} !== 6'b0)
            reportErr("ctrlAfterReset",
                      64'({RegWriteOut, MemReadOut, MemWriteOut, MemtoRegOut, BranchTaken, ACCEn}),
                      64'h0);
        if (Out !== '0) reportErr("OutAfterReset", Out, 64'h0);
        if (PCout !== '0) reportErr("PCoutAfterReset", 64'(PCout), 64'h0);

        // --------------------
        // Directed table, then random
        // --------------------
        for (int i = 0; i < NTBL; i++) stepVec(tbl[i], i > 0);
        for (int i = 0; i < NRND; i++) stepVec(randVec(), 1'b1);
        @(posedge Clock);
        #2;
        checkOut(prev);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
exPkg.sv
exCtrlIf.sv
exAlu.sv
exBranch.sv
exMult.sv
exControl.sv
exStage1.sv
exStageTop.sv
exStage_assert.sv
tbExStage.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tbExStage
FLIST     ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
